// ==== verilog/sr_pkg.sv ====
// Shared widths, address fields and types for the register-access path
// FIFO depths must be powers of two since pointers wrap by overflow
// APP_BITS must cover NUM_APPS exactly for the round-robin wrap
`default_nettype none

package sr_pkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------

	// Application slots
	localparam int NUM_APPS = 4;
	localparam int APP_BITS = 2;

	// Registers per slot, 8 bytes apart
	localparam int REG_BITS = 3;
	localparam int REG_LSB  = 3;

	// Slot number sits above the register index
	localparam int APP_LSB = 6;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	// --------------------------------------------------
	// Buffer depths, which also set starting credits
	// --------------------------------------------------

	// Route tree input buffer, host credits
	localparam int HOST_CREDITS = 2;
	// Slot request FIFO, route tree credits per slot
	localparam int SLOT_DEPTH = 4;
	// Merger FIFO per slot, response credits per slot
	localparam int RESP_DEPTH = 2;
	// Register stages on a slot request input
	localparam int PIPE_STAGES = 2;

	// --------------------------------------------------
	// Types
	// --------------------------------------------------

	typedef logic [ADDR_W-1:0]   sr_addr_t;
	typedef logic [DATA_W-1:0]   sr_data_t;
	typedef logic [APP_BITS-1:0] app_id_t;
	typedef logic [REG_BITS-1:0] reg_idx_t;

	// Holds 0..SLOT_DEPTH, the largest of the credit pools
	typedef logic [$clog2(SLOT_DEPTH+1)-1:0] credit_t;

	// Slot access FSM
	typedef enum logic [1:0] {
		SLOT_IDLE,
		SLOT_ACCESS,
		SLOT_WAIT_CREDIT
	} slot_state_t;

endpackage

`default_nettype wire

// ==== verilog/sr_route_tree.sv ====
// Host requests are buffered, decoded and steered to one slot each
// Host must obey its credits: the input buffer has no overflow check
// Head-of-line blocking when the head's slot has no credit
`default_nettype none

module sr_route_tree import sr_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	// Host request side
	input  logic                req_valid,
	input  logic                req_write,
	input  sr_addr_t            req_addr,
	input  sr_data_t            req_data,
	output logic                req_credit,
	// Toward the slots
	output logic [NUM_APPS-1:0] slot_req_valid,
	output logic                slot_req_write,
	output reg_idx_t            slot_req_idx,
	output sr_data_t            slot_req_data,
	input  logic [NUM_APPS-1:0] slot_req_credit
);

	// --------------------------------------------------
	// Input buffer
	// --------------------------------------------------

	logic                            buf_write [HOST_CREDITS];
	sr_addr_t                        buf_addr  [HOST_CREDITS];
	sr_data_t                        buf_data  [HOST_CREDITS];
	logic [$clog2(HOST_CREDITS)-1:0] wr_ptr;
	logic [$clog2(HOST_CREDITS)-1:0] rd_ptr;
	credit_t                         buf_cnt;

	// Head entry decode
	app_id_t  head_app;
	reg_idx_t head_idx;
	logic     dispatch;

	// Credits held toward each slot
	credit_t  slot_cnt [NUM_APPS];

	assign head_app = buf_addr[rd_ptr][APP_LSB +: APP_BITS];
	assign head_idx = buf_addr[rd_ptr][REG_LSB +: REG_BITS];

	// Leave only when the target slot still has room
	assign dispatch = (buf_cnt != '0) && (slot_cnt[head_app] != '0);

	// Buffer entry freed, so the host gets its credit back now
	assign req_credit = dispatch;

	// Head goes out combinationally, the slot registers it
	always_comb begin
		slot_req_valid = '0;
		if (dispatch)
			slot_req_valid[head_app] = 1'b1;
	end

	assign slot_req_write = buf_write[rd_ptr];
	assign slot_req_idx   = head_idx;
	assign slot_req_data  = buf_data[rd_ptr];

	// Buffer pointers and fill level
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			buf_cnt <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (dispatch)
				rd_ptr <= rd_ptr + 1'b1;
			buf_cnt <= buf_cnt + credit_t'(req_valid) - credit_t'(dispatch);
		end
	end

	// Payload storage
	always_ff @(posedge clk) begin
		if (req_valid) begin
			buf_write[wr_ptr] <= req_write;
			buf_addr[wr_ptr]  <= req_addr;
			buf_data[wr_ptr]  <= req_data;
		end
	end

	// --------------------------------------------------
	// Per-slot credit counters
	// --------------------------------------------------

	// Spent on dispatch, returned when the slot pops its FIFO
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_APPS; i++)
				slot_cnt[i] <= credit_t'(SLOT_DEPTH);
		end else begin
			for (int i = 0; i < NUM_APPS; i++)
				slot_cnt[i] <= slot_cnt[i]
					- credit_t'(dispatch && (head_app == app_id_t'(i)))
					+ credit_t'(slot_req_credit[i]);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sr_app_slot.sv ====
// One application slot holding a bank of 8 scratch registers
// Writes give no response, reads give one, in request order
// Upstream must obey the SLOT_DEPTH credit: no FIFO overflow check
`default_nettype none

module sr_app_slot import sr_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	// Requests from the route tree
	input  logic     req_valid,
	input  logic     req_write,
	input  reg_idx_t req_idx,
	input  sr_data_t req_data,
	output logic     req_credit,
	// Responses toward the merger
	output logic     resp_valid,
	output sr_data_t resp_data,
	input  logic     resp_credit
);

	// --------------------------------------------------
	// Input pipeline
	// --------------------------------------------------

	logic     pipe_valid [PIPE_STAGES];
	logic     pipe_write [PIPE_STAGES];
	reg_idx_t pipe_idx   [PIPE_STAGES];
	sr_data_t pipe_data  [PIPE_STAGES];

	// Request FIFO
	logic                          fifo_write [SLOT_DEPTH];
	reg_idx_t                      fifo_idx   [SLOT_DEPTH];
	sr_data_t                      fifo_data  [SLOT_DEPTH];
	logic [$clog2(SLOT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(SLOT_DEPTH)-1:0] rd_ptr;
	credit_t                       fifo_cnt;
	logic                          push;
	logic                          pop;

	// Access in progress
	slot_state_t state;
	logic        cur_write;
	reg_idx_t    cur_idx;
	sr_data_t    cur_data;
	credit_t     resp_cnt;
	logic        send;

	// Scratch registers
	sr_data_t bank [2**REG_BITS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < PIPE_STAGES; s++)
				pipe_valid[s] <= 1'b0;
		end else begin
			pipe_valid[0] <= req_valid;
			for (int s = 1; s < PIPE_STAGES; s++)
				pipe_valid[s] <= pipe_valid[s-1];
		end
	end

	always_ff @(posedge clk) begin
		pipe_write[0] <= req_write;
		pipe_idx[0]   <= req_idx;
		pipe_data[0]  <= req_data;
		for (int s = 1; s < PIPE_STAGES; s++) begin
			pipe_write[s] <= pipe_write[s-1];
			pipe_idx[s]   <= pipe_idx[s-1];
			pipe_data[s]  <= pipe_data[s-1];
		end
	end

	// --------------------------------------------------
	// Request FIFO
	// --------------------------------------------------

	assign push = pipe_valid[PIPE_STAGES-1];
	// One pop per access, only from idle
	assign pop  = (state == SLOT_IDLE) && (fifo_cnt != '0);
	// Freed FIFO entry goes back to the route tree
	assign req_credit = pop;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + credit_t'(push) - credit_t'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_write[wr_ptr] <= pipe_write[PIPE_STAGES-1];
			fifo_idx[wr_ptr]   <= pipe_idx[PIPE_STAGES-1];
			fifo_data[wr_ptr]  <= pipe_data[PIPE_STAGES-1];
		end
		// Latch the popped request for the access cycle
		if (pop) begin
			cur_write <= fifo_write[rd_ptr];
			cur_idx   <= fifo_idx[rd_ptr];
			cur_data  <= fifo_data[rd_ptr];
		end
		if (send)
			resp_data <= bank[cur_idx];
	end

	// --------------------------------------------------
	// Access FSM and register bank
	// --------------------------------------------------

	// A read responds once a merger credit is held
	assign send = !cur_write && (resp_cnt != '0)
		&& ((state == SLOT_ACCESS) || (state == SLOT_WAIT_CREDIT));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= SLOT_IDLE;
			resp_valid <= 1'b0;
			resp_cnt   <= credit_t'(RESP_DEPTH);
			for (int r = 0; r < 2**REG_BITS; r++)
				bank[r] <= '0;
		end else begin
			resp_valid <= send;
			resp_cnt   <= resp_cnt - credit_t'(send) + credit_t'(resp_credit);
			case (state)
				SLOT_IDLE: begin
					if (pop)
						state <= SLOT_ACCESS;
				end
				SLOT_ACCESS: begin
					if (cur_write) begin
						bank[cur_idx] <= cur_data;
						state         <= SLOT_IDLE;
					end else if (send) begin
						state <= SLOT_IDLE;
					end else begin
						state <= SLOT_WAIT_CREDIT;
					end
				end
				SLOT_WAIT_CREDIT: begin
					if (send)
						state <= SLOT_IDLE;
				end
				default: state <= SLOT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sr_resp_merge.sv ====
// Merges slot responses onto one host return path tagged by slot
// The host always accepts, there is no backpressure on resp_valid
// Order between slots follows a round-robin pointer and is not fixed
`default_nettype none

module sr_resp_merge import sr_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	// From the slots
	input  logic [NUM_APPS-1:0] slot_resp_valid,
	input  sr_data_t            slot_resp_data [NUM_APPS],
	output logic [NUM_APPS-1:0] slot_resp_credit,
	// Host return path
	output logic                resp_valid,
	output sr_data_t            resp_data,
	output app_id_t             resp_app
);

	// --------------------------------------------------
	// Response FIFOs, one per slot
	// --------------------------------------------------

	sr_data_t                      mem    [NUM_APPS][RESP_DEPTH];
	logic [$clog2(RESP_DEPTH)-1:0] wr_ptr [NUM_APPS];
	logic [$clog2(RESP_DEPTH)-1:0] rd_ptr [NUM_APPS];
	credit_t                       cnt    [NUM_APPS];

	// Arbitration
	app_id_t             rr_ptr;
	app_id_t             sel;
	logic                sel_valid;
	logic [NUM_APPS-1:0] pop;

	// First non-empty FIFO at or after the pointer
	always_comb begin
		app_id_t cand;
		sel       = rr_ptr;
		sel_valid = 1'b0;
		// Walk backwards so the nearest candidate wins
		for (int k = NUM_APPS - 1; k >= 0; k--) begin
			cand = rr_ptr + app_id_t'(k);
			if (cnt[cand] != '0) begin
				sel       = cand;
				sel_valid = 1'b1;
			end
		end
	end

	always_comb begin
		pop = '0;
		if (sel_valid)
			pop[sel] = 1'b1;
	end

	// Popped entry frees a slot credit
	assign slot_resp_credit = pop;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_APPS; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				cnt[i]    <= '0;
			end
			rr_ptr     <= '0;
			resp_valid <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_APPS; i++) begin
				if (slot_resp_valid[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				cnt[i] <= cnt[i] + credit_t'(slot_resp_valid[i]) - credit_t'(pop[i]);
			end
			// Next search starts just past the winner
			if (sel_valid)
				rr_ptr <= sel + 1'b1;
			resp_valid <= sel_valid;
		end
	end

	// Payload and tag
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_APPS; i++) begin
			if (slot_resp_valid[i])
				mem[i][wr_ptr[i]] <= slot_resp_data[i];
		end
		if (sel_valid) begin
			resp_data <= mem[sel][rd_ptr[sel]];
			resp_app  <= sel;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sr_top.sv ====
// Register-access path: route tree, NUM_APPS slots, response merger
// Host starts with HOST_CREDITS credits and regains one per req_credit
// Responses are always accepted by the host
`default_nettype none

module sr_top import sr_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	// Host requests
	input  logic     req_valid,
	input  logic     req_write,
	input  sr_addr_t req_addr,
	input  sr_data_t req_data,
	output logic     req_credit,
	// Host responses
	output logic     resp_valid,
	output sr_data_t resp_data,
	output app_id_t  resp_app
);

	// --------------------------------------------------
	// Route tree to slots
	// --------------------------------------------------

	logic [NUM_APPS-1:0] slot_req_valid;
	logic                slot_req_write;
	reg_idx_t            slot_req_idx;
	sr_data_t            slot_req_data;
	logic [NUM_APPS-1:0] slot_req_credit;

	// Slots to merger
	logic [NUM_APPS-1:0] slot_resp_valid;
	sr_data_t            slot_resp_data [NUM_APPS];
	logic [NUM_APPS-1:0] slot_resp_credit;

	sr_route_tree route_tree_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.req_valid       (req_valid),
		.req_write       (req_write),
		.req_addr        (req_addr),
		.req_data        (req_data),
		.req_credit      (req_credit),
		.slot_req_valid  (slot_req_valid),
		.slot_req_write  (slot_req_write),
		.slot_req_idx    (slot_req_idx),
		.slot_req_data   (slot_req_data),
		.slot_req_credit (slot_req_credit)
	);

	// --------------------------------------------------
	// Application slots
	// --------------------------------------------------

	// Shared payload, per-slot valid and credits
	for (genvar i = 0; i < NUM_APPS; i++) begin : app
		sr_app_slot slot_i (
			.clk         (clk),
			.arst_n      (arst_n),
			.req_valid   (slot_req_valid[i]),
			.req_write   (slot_req_write),
			.req_idx     (slot_req_idx),
			.req_data    (slot_req_data),
			.req_credit  (slot_req_credit[i]),
			.resp_valid  (slot_resp_valid[i]),
			.resp_data   (slot_resp_data[i]),
			.resp_credit (slot_resp_credit[i])
		);
	end

	sr_resp_merge resp_merge_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.slot_resp_valid  (slot_resp_valid),
		.slot_resp_data   (slot_resp_data),
		.slot_resp_credit (slot_resp_credit),
		.resp_valid       (resp_valid),
		.resp_data        (resp_data),
		.resp_app         (resp_app)
	);

endmodule

`default_nettype wire

// ==== sim/sr_assertions.sv ====
// Credit and response rules on the host side of sr_top
// Host credit count is spent on req_valid and regained on req_credit
`default_nettype none

module sr_assertions import sr_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	input logic    req_valid,
	input logic    req_credit,
	input logic    resp_valid,
	input app_id_t resp_app
);

	// Credits the host holds right now
	int host_cr;

	// Assertion failures seen so far
	int fail_cnt = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			host_cr <= HOST_CREDITS;
		else
			host_cr <= host_cr - int'(req_valid) + int'(req_credit);
	end

	// --------------------------------------------------
	// Rules
	// --------------------------------------------------

	// No request without a credit
	a_req_has_credit: assert property (@(posedge clk) disable iff (!arst_n)
		req_valid |-> (host_cr != 0))
		else begin
			fail_cnt++;
			$error("request sent while the host held no credit");
		end

	// Tag must be known on every response
	a_resp_app_known: assert property (@(posedge clk) disable iff (!arst_n)
		resp_valid |-> !$isunknown(resp_app))
		else begin
			fail_cnt++;
			$error("resp_app unknown while resp_valid is high");
		end

	// Returned credits never exceed the input buffer
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		host_cr <= HOST_CREDITS)
		else begin
			fail_cnt++;
			$error("host credit count above the input buffer depth");
		end

endmodule

bind sr_top sr_assertions sr_assertions_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req_credit (req_credit),
	.resp_valid (resp_valid),
	.resp_app   (resp_app)
);

`default_nettype wire

// ==== sim/sr_tb.sv ====
// Self-checking testbench for the register-access path
// Read data is predicted by a per-slot register model kept in issue order
// Reads to a new slot wait until earlier reads have drained, so each tag is known
`default_nettype none

module sr_tb import sr_pkg::*; ();

	localparam int N_ENTRIES  = 28;
	localparam int MAX_CYCLES = N_ENTRIES * 40 + 100;
	localparam int QLEN       = 64;

	logic     clk;
	logic     arst_n;
	logic     req_valid;
	logic     req_write;
	sr_addr_t req_addr;
	sr_data_t req_data;
	logic     req_credit;
	logic     resp_valid;
	sr_data_t resp_data;
	app_id_t  resp_app;

	// --------------------------------------------------
	// Stimulus table and reference model
	// --------------------------------------------------

	int       t_test  [N_ENTRIES];
	logic     t_write [N_ENTRIES];
	app_id_t  t_app   [N_ENTRIES];
	reg_idx_t t_idx   [N_ENTRIES];
	sr_addr_t t_fill  [N_ENTRIES];
	sr_data_t t_data  [N_ENTRIES];
	int       n_entries = 0;

	sr_data_t model [NUM_APPS][2**REG_BITS];

	// Expected reads kept as one ring per slot
	sr_data_t exp_data [NUM_APPS][QLEN];
	int       q_head   [NUM_APPS];
	int       q_tail   [NUM_APPS];

	// Slot whose reads are outstanding
	app_id_t  rd_slot;

	// Bookkeeping
	int sent       = 0;
	int returned   = 0;
	int reads_sent = 0;
	int resp_seen  = 0;
	int errors     = 0;
	int checks     = 0;
	int cycles     = 0;

	sr_top sr_top_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req_write  (req_write),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_credit (req_credit),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_app   (resp_app)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Hard limit on run length
	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	// Slot and register fields placed over arbitrary filler bits
	function automatic sr_addr_t make_addr(input app_id_t app, input reg_idx_t idx,
		input sr_addr_t fill);
		sr_addr_t a;
		a = fill;
		a[APP_LSB +: APP_BITS] = app;
		a[REG_LSB +: REG_BITS] = idx;
		return a;
	endfunction

	task automatic add(input int test, input logic wr, input int app, input int idx,
		input sr_addr_t fill, input sr_data_t data);
		t_test[n_entries]  = test;
		t_write[n_entries] = wr;
		t_app[n_entries]   = app_id_t'(app);
		t_idx[n_entries]   = reg_idx_t'(idx);
		t_fill[n_entries]  = fill;
		t_data[n_entries]  = data;
		n_entries++;
	endtask

	task automatic fill_table();
		// Reset values in every slot
		add(1, 1'b0, 0, 0, '0, '0);
		add(1, 1'b0, 1, 3, '0, '0);
		add(1, 1'b0, 2, 7, '0, '0);
		add(1, 1'b0, 3, 4, '0, '0);
		// Write then read back
		add(2, 1'b1, 1, 2, '0, {$urandom, $urandom});
		add(2, 1'b0, 1, 2, '0, '0);
		add(2, 1'b1, 3, 6, '0, {$urandom, $urandom});
		add(2, 1'b0, 3, 6, '0, '0);
		// Same index with its own value in each slot
		for (int s = 0; s < NUM_APPS; s++)
			add(3, 1'b1, s, 5, '0, {32'ha000_0000 + 32'(s), $urandom});
		for (int s = 0; s < NUM_APPS; s++)
			add(3, 1'b0, s, 5, '0, '0);
		// Burst into one slot
		for (int r = 0; r < 4; r++)
			add(4, 1'b1, 2, r, '0, {$urandom, $urandom});
		for (int r = 0; r < 4; r++)
			add(4, 1'b0, 2, r, '0, '0);
		// Filler bits outside the fields differ
		add(5, 1'b1, 0, 1, 32'hdead_bf37, 64'h0123_4567_89ab_cdef);
		add(5, 1'b0, 0, 1, 32'h5a00_0002, '0);
		add(5, 1'b1, 3, 7, 32'hffff_ff3f, {$urandom, $urandom});
		add(5, 1'b0, 3, 7, 32'h0000_8001, '0);
	endtask

	task automatic check_data(input sr_data_t got, input sr_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: resp_data is %h, expected %h", got, exp);
		end
	endtask

	task automatic check_app(input app_id_t got, input app_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: resp_app is %h, expected %h", got, exp);
		end
	endtask

	// Sends one entry once a credit is held
	// Starts and ends on a rising edge
	task automatic issue(input int e);
		app_id_t a;
		a = t_app[e];
		// A read to another slot waits for earlier reads to drain
		while (!t_write[e] && (resp_seen != reads_sent) && (rd_slot != a)) begin
			req_valid <= 1'b0;
			@(posedge clk);
		end
		while (sent - returned >= HOST_CREDITS) begin
			req_valid <= 1'b0;
			@(posedge clk);
		end
		req_valid <= 1'b1;
		req_write <= t_write[e];
		req_addr  <= make_addr(a, t_idx[e], t_fill[e]);
		req_data  <= t_data[e];
		sent++;
		if (t_write[e]) begin
			model[a][t_idx[e]] = t_data[e];
		end else begin
			exp_data[a][q_tail[a] % QLEN] = model[a][t_idx[e]];
			q_tail[a]++;
			reads_sent++;
			rd_slot = a;
		end
		@(posedge clk);
	endtask

	// --------------------------------------------------
	// Response monitor sampled mid-cycle
	// --------------------------------------------------

	always @(negedge clk) begin : monitor
		app_id_t s;
		if (arst_n === 1'b1) begin
			if (req_credit === 1'b1) begin
				if (returned >= sent) begin
					errors++;
					$display("req_credit pulsed with no request outstanding");
				end
				returned++;
			end
			if (resp_valid === 1'b1) begin
				resp_seen++;
				s = rd_slot;
				if (q_head[s] == q_tail[s]) begin
					errors++;
					$display("response arrived with no read outstanding");
				end else begin
					check_app(resp_app, s);
					check_data(resp_data, exp_data[s][q_head[s] % QLEN]);
					q_head[s]++;
				end
			end
		end
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		int      err_start;
		string   names [1:6];
		names[1] = "reads after reset";
		names[2] = "write then read";
		names[3] = "slot isolation";
		names[4] = "burst to one slot";
		names[5] = "ignored address bits";
		names[6] = "credit and response counts";
		void'($urandom(32'hba7a_6913));
		arst_n    = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_data  = '0;
		rd_slot   = '0;
		for (int s = 0; s < NUM_APPS; s++) begin
			q_head[s] = 0;
			q_tail[s] = 0;
			for (int r = 0; r < 2**REG_BITS; r++)
				model[s][r] = '0;
		end
		fill_table();
		if (n_entries != N_ENTRIES) begin
			errors++;
			$display("stimulus table holds %0d entries instead of %0d", n_entries, N_ENTRIES);
		end
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		for (int t = 1; t <= 5; t++) begin
			err_start = errors;
			for (int e = 0; e < n_entries; e++)
				if (t_test[e] == t)
					issue(e);
			req_valid <= 1'b0;
			// Drain all reads of this test
			while (resp_seen != reads_sent)
				@(posedge clk);
			$display("test %0d %s: %0d errors", t, names[t], errors - err_start);
		end

		// Every request dispatched before a quiet spell for stray responses
		err_start = errors;
		while (returned < sent)
			@(posedge clk);
		repeat (20) @(posedge clk);
		if (returned != sent) begin
			errors++;
			$display("%0d req_credit pulses for %0d requests", returned, sent);
		end
		if (resp_seen != reads_sent) begin
			errors++;
			$display("%0d responses for %0d reads", resp_seen, reads_sent);
		end
		$display("test 6 %s: %0d errors", names[6], errors - err_start);

		if (sr_top_i.sr_assertions_i.fail_cnt != 0) begin
			errors += sr_top_i.sr_assertions_i.fail_cnt;
			$display("%0d bound assertion failures", sr_top_i.sr_assertions_i.fail_cnt);
		end

		$display("summary: %0d requests, %0d responses, %0d checks, %0d errors",
			sent, resp_seen, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/sr_pkg.sv
verilog/sr_route_tree.sv
verilog/sr_app_slot.sv
verilog/sr_resp_merge.sv
verilog/sr_top.sv
sim/sr_assertions.sv
sim/sr_tb.sv

// ==== Bender.yml ====
package:
  name: sr_regpath

sources:
  - files:
      - verilog/sr_pkg.sv
      - verilog/sr_route_tree.sv
      - verilog/sr_app_slot.sv
      - verilog/sr_resp_merge.sv
      - verilog/sr_top.sv
  - target: simulation
    files:
      - sim/sr_assertions.sv
      - sim/sr_tb.sv
